//--- common/pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// Datapath and register file sizes
`define PIPE_XLEN       64
`define PIPE_INST_W     32
`define PIPE_REG_IDX_W  5
`define PIPE_NUM_REGS   32
`define PIPE_ZERO_REG   5'd31

////////////////////
// Function codes, instruction bits 11:5

// Arithmetic group (op_inta)
`define PIPE_FUNC_ADDQ   7'h20
`define PIPE_FUNC_SUBQ   7'h29
`define PIPE_FUNC_CMPEQ  7'h2d
`define PIPE_FUNC_CMPULT 7'h1d

// Logic group (op_intl), BIS shares its code with ADDQ
`define PIPE_FUNC_AND    7'h00
`define PIPE_FUNC_BIS    7'h20
`define PIPE_FUNC_XOR    7'h40

// Shift group (op_ints)
`define PIPE_FUNC_SLL    7'h39
`define PIPE_FUNC_SRL    7'h34

`endif

//--- common/pipe_pkg.sv
`default_nettype none

`include "pipe_macros.svh"

package pipe_pkg;

  // Major opcode, instruction bits 31:26
  typedef enum logic [5:0] {
    op_pal  = 6'h00,
    op_inta = 6'h10,
    op_intl = 6'h11,
    op_ints = 6'h12
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_cmpeq,
    alu_cmpult,
    alu_and,
    alu_bis,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_none
  } alu_op_t;

  typedef enum logic [1:0] {
    no_error,
    halted_on_halt,
    halted_on_illegal
  } error_status_t;

  // Decode to execute record
  typedef struct packed {
    logic                       valid;
    alu_op_t                    alu_op;
    logic [`PIPE_REG_IDX_W-1:0] ra_idx;
    logic [`PIPE_REG_IDX_W-1:0] rb_idx;
    logic [`PIPE_REG_IDX_W-1:0] dest_idx;
    logic                       use_literal;
    logic [7:0]                 literal;
    logic                       wr_en;
    logic                       halt;
    logic                       illegal;
    logic [`PIPE_INST_W-1:0]    ir;
  } decoded_inst_t;

  // Execute to result record
  typedef struct packed {
    logic                       valid;
    logic                       wr_en;
    logic [`PIPE_REG_IDX_W-1:0] dest_idx;
    logic [`PIPE_XLEN-1:0]      data;
    logic                       halt;
    logic                       illegal;
    logic [`PIPE_INST_W-1:0]    ir;
  } exec_result_t;

  // Register file write, also the bypass source
  typedef struct packed {
    logic                       en;
    logic [`PIPE_REG_IDX_W-1:0] idx;
    logic [`PIPE_XLEN-1:0]      data;
  } reg_write_t;

endpackage

`default_nettype wire

//--- execute/regfile.sv
`default_nettype none

`include "pipe_macros.svh"

module regfile (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [`PIPE_REG_IDX_W-1:0] rd_a_idx,
  input  logic [`PIPE_REG_IDX_W-1:0] rd_b_idx,
  input  pipe_pkg::reg_write_t       write,
  output logic [`PIPE_XLEN-1:0]      rd_a_data,
  output logic [`PIPE_XLEN-1:0]      rd_b_data
);

  logic [`PIPE_XLEN-1:0] regs [`PIPE_NUM_REGS];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < `PIPE_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (write.en)
    begin
      regs[write.idx] <= write.data;
    end
  end

  // Register 31 reads as zero
  assign rd_a_data = (rd_a_idx == `PIPE_ZERO_REG) ? '0 : regs[rd_a_idx];
  assign rd_b_data = (rd_b_idx == `PIPE_ZERO_REG) ? '0 : regs[rd_b_idx];

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`default_nettype none

`include "pipe_macros.svh"

module decode_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    inst_valid,
  input  logic [`PIPE_INST_W-1:0] inst,
  output pipe_pkg::decoded_inst_t decoded
);

  pipe_pkg::opcode_t       opcode;
  logic [6:0]              func;
  pipe_pkg::decoded_inst_t next_rec;

  assign opcode = pipe_pkg::opcode_t'(inst[31:26]);
  assign func   = inst[11:5];

  ////////////////////
  // Field extraction and function mapping

  always_comb
  begin
    next_rec             = '0;
    next_rec.valid       = inst_valid;
    next_rec.ra_idx      = inst[25:21];
    next_rec.rb_idx      = inst[20:16];
    next_rec.dest_idx    = inst[4:0];
    next_rec.use_literal = inst[12];   // Literal form
    next_rec.literal     = inst[20:13];
    next_rec.ir          = inst;
    next_rec.alu_op      = pipe_pkg::alu_none;

    case (opcode)
      pipe_pkg::op_inta:
        case (func)
          `PIPE_FUNC_ADDQ:   next_rec.alu_op = pipe_pkg::alu_add;
          `PIPE_FUNC_SUBQ:   next_rec.alu_op = pipe_pkg::alu_sub;
          `PIPE_FUNC_CMPEQ:  next_rec.alu_op = pipe_pkg::alu_cmpeq;
          `PIPE_FUNC_CMPULT: next_rec.alu_op = pipe_pkg::alu_cmpult;
          default:           next_rec.alu_op = pipe_pkg::alu_none;
        endcase
      pipe_pkg::op_intl:
        case (func)
          `PIPE_FUNC_AND:    next_rec.alu_op = pipe_pkg::alu_and;
          `PIPE_FUNC_BIS:    next_rec.alu_op = pipe_pkg::alu_bis;
          `PIPE_FUNC_XOR:    next_rec.alu_op = pipe_pkg::alu_xor;
          default:           next_rec.alu_op = pipe_pkg::alu_none;
        endcase
      pipe_pkg::op_ints:
        case (func)
          `PIPE_FUNC_SLL:    next_rec.alu_op = pipe_pkg::alu_sll;
          `PIPE_FUNC_SRL:    next_rec.alu_op = pipe_pkg::alu_srl;
          default:           next_rec.alu_op = pipe_pkg::alu_none;
        endcase
      default:               next_rec.alu_op = pipe_pkg::alu_none;
    endcase

    // Halt is the all-zero PAL word
    next_rec.halt    = (opcode == pipe_pkg::op_pal) && (inst[25:0] == 26'd0);
    next_rec.illegal = (next_rec.alu_op == pipe_pkg::alu_none) && !next_rec.halt;
    next_rec.wr_en   = inst_valid && !next_rec.illegal && !next_rec.halt
                       && (next_rec.dest_idx != `PIPE_ZERO_REG);
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      decoded <= '0;
    else
      decoded <= next_rec;
  end

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
`default_nettype none

`include "pipe_macros.svh"

module execute_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  pipe_pkg::decoded_inst_t decoded,
  input  pipe_pkg::reg_write_t    write_back,
  output pipe_pkg::exec_result_t  result
);

  logic [`PIPE_XLEN-1:0] rf_a;
  logic [`PIPE_XLEN-1:0] rf_b;
  logic [`PIPE_XLEN-1:0] op_a;
  logic [`PIPE_XLEN-1:0] op_b;
  logic [`PIPE_XLEN-1:0] alu_out;
  logic [5:0]            shamt;

  regfile regfile_i (
    .clock     (clock),
    .reset     (reset),
    .rd_a_idx  (decoded.ra_idx),
    .rd_b_idx  (decoded.rb_idx),
    .write     (write_back),
    .rd_a_data (rf_a),
    .rd_b_data (rf_b)
  );

  ////////////////////
  // Operand select

  always_comb
  begin
    op_a = rf_a;
    op_b = rf_b;
    if (write_back.en && (write_back.idx == decoded.ra_idx))
      op_a = write_back.data;   // Producer one ahead
    if (write_back.en && (write_back.idx == decoded.rb_idx))
      op_b = write_back.data;
    if (decoded.use_literal)
      op_b = {{(`PIPE_XLEN-8){1'b0}}, decoded.literal};
  end

  assign shamt = op_b[5:0];

  ////////////////////
  // ALU

  always_comb
  begin
    case (decoded.alu_op)
      pipe_pkg::alu_add:    alu_out = op_a + op_b;
      pipe_pkg::alu_sub:    alu_out = op_a - op_b;
      pipe_pkg::alu_cmpeq:  alu_out = {{(`PIPE_XLEN-1){1'b0}}, (op_a == op_b)};
      pipe_pkg::alu_cmpult: alu_out = {{(`PIPE_XLEN-1){1'b0}}, (op_a < op_b)};
      pipe_pkg::alu_and:    alu_out = op_a & op_b;
      pipe_pkg::alu_bis:    alu_out = op_a | op_b;
      pipe_pkg::alu_xor:    alu_out = op_a ^ op_b;
      pipe_pkg::alu_sll:    alu_out = op_a << shamt;
      pipe_pkg::alu_srl:    alu_out = op_a >> shamt;
      default:              alu_out = '0;   // Halt and illegal
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      result <= '0;
    end
    else
    begin
      result.valid    <= decoded.valid;
      result.wr_en    <= decoded.wr_en;
      result.dest_idx <= decoded.dest_idx;
      result.data     <= alu_out;
      result.halt     <= decoded.halt;
      result.illegal  <= decoded.illegal;
      result.ir       <= decoded.ir;
    end
  end

endmodule

`default_nettype wire

//--- result/result_stage.sv
`default_nettype none

`include "pipe_macros.svh"

module result_stage (
  input  logic                       clock,
  input  logic                       reset,
  input  pipe_pkg::exec_result_t     result,
  output pipe_pkg::reg_write_t       write_back,
  output logic                       commit_valid,
  output logic                       commit_wr_en,
  output logic [`PIPE_REG_IDX_W-1:0] commit_wr_idx,
  output logic [`PIPE_XLEN-1:0]      commit_wr_data,
  output logic [`PIPE_INST_W-1:0]    commit_ir,
  output pipe_pkg::error_status_t    error_status
);

  logic halted;

  assign halted = (error_status != pipe_pkg::no_error);

  // Nothing retires once stopped
  assign commit_valid   = result.valid && !halted;
  assign commit_wr_en   = commit_valid && result.wr_en;
  assign commit_wr_idx  = result.dest_idx;
  assign commit_wr_data = result.data;
  assign commit_ir      = result.ir;

  assign write_back = '{en: commit_wr_en, idx: result.dest_idx, data: result.data};

  ////////////////////
  // Sticky status

  always_ff @(posedge clock)
  begin
    if (reset)
      error_status <= pipe_pkg::no_error;
    else if (commit_valid && result.halt)
      error_status <= pipe_pkg::halted_on_halt;
    else if (commit_valid && result.illegal)
      error_status <= pipe_pkg::halted_on_illegal;
  end

endmodule

`default_nettype wire

//--- logic/op_pipeline.sv
`default_nettype none

`include "pipe_macros.svh"

module op_pipeline (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       inst_valid,
  input  logic [`PIPE_INST_W-1:0]    inst,
  output logic                       commit_valid,
  output logic                       commit_wr_en,
  output logic [`PIPE_REG_IDX_W-1:0] commit_wr_idx,
  output logic [`PIPE_XLEN-1:0]      commit_wr_data,
  output logic [`PIPE_INST_W-1:0]    commit_ir,
  output pipe_pkg::error_status_t    error_status
);

  pipe_pkg::decoded_inst_t decoded;   // Decode to execute
  pipe_pkg::exec_result_t  result;    // Execute to result
  pipe_pkg::reg_write_t    write_back;

  decode_stage decode_stage_i (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .decoded    (decoded)
  );

  execute_stage execute_stage_i (
    .clock      (clock),
    .reset      (reset),
    .decoded    (decoded),
    .write_back (write_back),
    .result     (result)
  );

  result_stage result_stage_i (
    .clock          (clock),
    .reset          (reset),
    .result         (result),
    .write_back     (write_back),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .commit_ir      (commit_ir),
    .error_status   (error_status)
  );

endmodule

`default_nettype wire

//--- sim/op_pipeline_checker.sv
`default_nettype none

`include "pipe_macros.svh"

module op_pipeline_checker (
  input logic                       clock,
  input logic                       reset,
  input logic                       commit_valid,
  input logic                       commit_wr_en,
  input logic [`PIPE_REG_IDX_W-1:0] commit_wr_idx,
  input pipe_pkg::error_status_t    error_status
);

  // A write only happens as part of a commit
  wr_en_needs_valid: assert property (@(posedge clock) disable iff (reset)
    commit_wr_en |-> commit_valid)
    else $error("commit_wr_en high without commit_valid");

  status_sticky: assert property (@(posedge clock) disable iff (reset)
    (error_status != pipe_pkg::no_error) |=> $stable(error_status))
    else $error("error_status changed after the pipeline stopped");

  no_commit_when_stopped: assert property (@(posedge clock) disable iff (reset)
    (error_status != pipe_pkg::no_error) |-> !commit_valid)
    else $error("commit_valid high while error_status is set");

  // Zero register is never a write target
  no_zero_write: assert property (@(posedge clock) disable iff (reset)
    commit_wr_en |-> (commit_wr_idx != `PIPE_ZERO_REG))
    else $error("commit write to register 31");

endmodule

bind op_pipeline op_pipeline_checker op_pipeline_checker_i (
  .clock         (clock),
  .reset         (reset),
  .commit_valid  (commit_valid),
  .commit_wr_en  (commit_wr_en),
  .commit_wr_idx (commit_wr_idx),
  .error_status  (error_status)
);

`default_nettype wire

//--- sim/op_pipeline_tb.sv
`default_nettype none

`include "pipe_macros.svh"

module op_pipeline_tb;

  // Expected commit of one table row
  typedef struct packed {
    logic                       valid;
    logic                       wr_en;
    logic [`PIPE_REG_IDX_W-1:0] idx;
    logic [`PIPE_XLEN-1:0]      data;
  } commit_t;

  localparam logic [5:0] opa = 6'h10;   // Arithmetic group
  localparam logic [5:0] opl = 6'h11;   // Logic group
  localparam logic [5:0] ops = 6'h12;   // Shift group

  logic                       clock = 1'b0;
  logic                       reset;
  logic                       inst_valid;
  logic [`PIPE_INST_W-1:0]    inst;
  logic                       commit_valid;
  logic                       commit_wr_en;
  logic [`PIPE_REG_IDX_W-1:0] commit_wr_idx;
  logic [`PIPE_XLEN-1:0]      commit_wr_data;
  logic [`PIPE_INST_W-1:0]    commit_ir;
  pipe_pkg::error_status_t    error_status;

  string                   names[$];
  int                      segs[$];
  bit                      gap_ok[$];
  logic [`PIPE_INST_W-1:0] words[$];
  commit_t                 exps[$];
  int                      gaps[$];
  int                      exp_list[$];   // Rows that must commit, in order

  int error_count   = 0;
  int cycle_count   = 0;
  int cycle_limit   = 0;
  int exp_pos       = 0;
  int segment_limit = 0;
  int seed_value;
  int gap_sum;

  op_pipeline op_pipeline_i (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .commit_ir      (commit_ir),
    .error_status   (error_status)
  );

  always #10 clock = ~clock;

  ////////////////////
  // Instruction encoding

  function automatic logic [31:0] reg_word(input logic [5:0] opc, input logic [4:0] ra,
                                           input logic [4:0] rb, input logic [6:0] func,
                                           input logic [4:0] rc);
    return {opc, ra, rb, 4'b0000, func, rc};
  endfunction

  function automatic logic [31:0] lit_word(input logic [5:0] opc, input logic [4:0] ra,
                                           input logic [7:0] lit, input logic [6:0] func,
                                           input logic [4:0] rc);
    return {opc, ra, lit, 1'b1, func, rc};
  endfunction

  task automatic add_entry(input string name, input int seg, input bit gap,
                           input logic [31:0] word, input logic valid, input logic wr_en,
                           input logic [4:0] idx, input logic [63:0] data);
    commit_t rec;
    rec = '{valid: valid, wr_en: wr_en, idx: idx, data: data};
    names.push_back(name);
    segs.push_back(seg);
    gap_ok.push_back(gap);
    words.push_back(word);
    exps.push_back(rec);
  endtask

  ////////////////////
  // Stimulus table, all registers zero at the start

  task automatic build_table();
    add_entry("lit_bis_r1", 1, 1, lit_word(opl, 31, 5, `PIPE_FUNC_BIS, 1), 1, 1, 1, 64'd5);
    add_entry("lit_bis_r2", 1, 1, lit_word(opl, 31, 200, `PIPE_FUNC_BIS, 2), 1, 1, 2, 64'd200);
    add_entry("lit_add_r3", 1, 1, lit_word(opa, 31, 255, `PIPE_FUNC_ADDQ, 3), 1, 1, 3, 64'd255);
    add_entry("sub_r4", 1, 1, reg_word(opa, 31, 1, `PIPE_FUNC_SUBQ, 4), 1, 1, 4,
              64'hffff_ffff_ffff_fffb);
    add_entry("add_wrap_r5", 1, 0, lit_word(opa, 4, 10, `PIPE_FUNC_ADDQ, 5), 1, 1, 5, 64'd5);
    add_entry("add_r6", 1, 0, reg_word(opa, 1, 2, `PIPE_FUNC_ADDQ, 6), 1, 1, 6, 64'd205);
    add_entry("cmpeq_r7", 1, 0, reg_word(opa, 5, 1, `PIPE_FUNC_CMPEQ, 7), 1, 1, 7, 64'd1);
    add_entry("cmpeq_r8", 1, 1, reg_word(opa, 1, 2, `PIPE_FUNC_CMPEQ, 8), 1, 1, 8, 64'd0);
    add_entry("cmpult_r9", 1, 1, reg_word(opa, 2, 4, `PIPE_FUNC_CMPULT, 9), 1, 1, 9, 64'd1);
    add_entry("cmpult_r10", 1, 1, reg_word(opa, 4, 2, `PIPE_FUNC_CMPULT, 10), 1, 1, 10, 64'd0);
    add_entry("and_r11", 1, 1, reg_word(opl, 3, 2, `PIPE_FUNC_AND, 11), 1, 1, 11, 64'd200);
    add_entry("xor_r12", 1, 1, reg_word(opl, 3, 2, `PIPE_FUNC_XOR, 12), 1, 1, 12, 64'h37);
    add_entry("bis_r13", 1, 1, reg_word(opl, 1, 2, `PIPE_FUNC_BIS, 13), 1, 1, 13, 64'd205);
    add_entry("sll_r14", 1, 1, lit_word(ops, 3, 60, `PIPE_FUNC_SLL, 14), 1, 1, 14,
              64'hf000_0000_0000_0000);
    add_entry("srl_r15", 1, 0, lit_word(ops, 14, 4, `PIPE_FUNC_SRL, 15), 1, 1, 15,
              64'h0f00_0000_0000_0000);
    add_entry("srl_r16", 1, 0, reg_word(ops, 14, 1, `PIPE_FUNC_SRL, 16), 1, 1, 16,
              64'h0780_0000_0000_0000);
    add_entry("sll_mask_r17", 1, 1, lit_word(ops, 1, 66, `PIPE_FUNC_SLL, 17), 1, 1, 17, 64'd20);
    add_entry("write_r31", 1, 1, lit_word(opa, 1, 1, `PIPE_FUNC_ADDQ, 31), 1, 0, 31, 64'd0);
    add_entry("read_r31", 1, 0, reg_word(opl, 31, 31, `PIPE_FUNC_BIS, 18), 1, 1, 18, 64'd0);
    add_entry("illegal", 1, 1, reg_word(opa, 1, 2, 7'h7f, 19), 1, 0, 19, 64'd0);
    add_entry("after_illegal", 1, 0, lit_word(opl, 31, 7, `PIPE_FUNC_BIS, 20), 0, 0, 0, 64'd0);
    // A halt behind the illegal word must not change the status
    add_entry("halt_after_illegal", 1, 0, 32'h0000_0000, 0, 0, 0, 64'd0);
    // Second segment starts from reset
    add_entry("reset_r1", 2, 1, reg_word(opl, 1, 31, `PIPE_FUNC_BIS, 22), 1, 1, 22, 64'd0);
    add_entry("reset_r14", 2, 1, lit_word(opa, 14, 0, `PIPE_FUNC_ADDQ, 23), 1, 1, 23, 64'd0);
    add_entry("halt", 2, 1, 32'h0000_0000, 1, 0, 0, 64'd0);
    add_entry("after_halt", 2, 0, lit_word(opl, 31, 9, `PIPE_FUNC_BIS, 24), 0, 0, 0, 64'd0);
  endtask

  ////////////////////
  // Commit monitor

  task automatic compare_commit(input int row);
    assert (commit_ir == words[row])
    else
    begin
      $display("FAILED %s ir: expected %h, actual %h", names[row], words[row], commit_ir);
      error_count++;
    end
    assert (commit_wr_en == exps[row].wr_en)
    else
    begin
      $display("FAILED %s wr_en: expected %0b, actual %0b", names[row], exps[row].wr_en,
               commit_wr_en);
      error_count++;
    end
    if (exps[row].wr_en)
    begin
      assert (commit_wr_idx == exps[row].idx)
      else
      begin
        $display("FAILED %s idx: expected %0d, actual %0d", names[row], exps[row].idx,
                 commit_wr_idx);
        error_count++;
      end
      assert (commit_wr_data == exps[row].data)
      else
      begin
        $display("FAILED %s data: expected %h, actual %h", names[row], exps[row].data,
                 commit_wr_data);
        error_count++;
      end
    end
  endtask

  always @(negedge clock)
  begin
    if (!reset && commit_valid)
    begin
      assert (exp_pos < segment_limit)
      else
      begin
        $display("Unexpected commit of instruction %h after the pipeline stopped", commit_ir);
        error_count++;
      end
      if (exp_pos < segment_limit)
      begin
        compare_commit(exp_list[exp_pos]);
        exp_pos++;
      end
    end
  end

  always @(posedge clock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Run timed out after %0d cycles before all commits were seen", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // Segments

  task automatic apply_reset();
    @(posedge clock);
    #1 reset = 1'b1;
    inst_valid = 1'b0;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
  endtask

  task automatic run_segment(input int seg, input pipe_pkg::error_status_t exp_status);
    int target;
    target = 0;
    for (int i = 0; i < names.size(); i++)
      if (segs[i] <= seg && exps[i].valid)
        target++;
    segment_limit = target;
    for (int i = 0; i < names.size(); i++)
    begin
      if (segs[i] == seg)
      begin
        repeat (gaps[i])
        begin
          @(posedge clock);
          #1 inst_valid = 1'b0;
        end
        @(posedge clock);
        #1 inst_valid = 1'b1;
        inst = words[i];
      end
    end
    @(posedge clock);
    #1 inst_valid = 1'b0;
    inst = '0;
    while (exp_pos < target)
      @(posedge clock);
    repeat (3) @(posedge clock);   // Pipeline depth, any stray commit shows up here
    assert (error_status == exp_status)
    else
    begin
      $display("FAILED segment %0d status: expected %s, actual %s", seg, exp_status.name(),
               error_status.name());
      error_count++;
    end
  endtask

  initial
  begin
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    seed_value = $urandom(32'h30ef);
    build_table();
    gap_sum = 0;
    for (int i = 0; i < names.size(); i++)
    begin
      gaps.push_back(gap_ok[i] ? int'($urandom_range(2, 0)) : 0);
      gap_sum += gaps[i];
      if (exps[i].valid)
        exp_list.push_back(i);
    end
    cycle_limit = 2 * names.size() + gap_sum + 20;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
    run_segment(1, pipe_pkg::halted_on_illegal);
    apply_reset();
    run_segment(2, pipe_pkg::halted_on_halt);
    $display("Commits checked: %0d, errors: %0d", exp_pos, error_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/pipe_pkg.sv
execute/regfile.sv
decode/decode_stage.sv
execute/execute_stage.sv
result/result_stage.sv
logic/op_pipeline.sv
sim/op_pipeline_checker.sv
sim/op_pipeline_tb.sv

//--- Bender.yml
package:
  name: op_pipeline

export_include_dirs:
  - common

sources:
  - common/pipe_pkg.sv
  - execute/regfile.sv
  - decode/decode_stage.sv
  - execute/execute_stage.sv
  - result/result_stage.sv
  - logic/op_pipeline.sv
  - target: simulation
    files:
      - sim/op_pipeline_checker.sv
      - sim/op_pipeline_tb.sv
